/* compile.f */
hw/mem_types_pkg.sv
hw/arb_pkg.sv
hw/load_align.sv
hw/rd_arbiter.sv
hw/read_memory.sv
hw/mem_read_subsys.sv
testbench/rd_arbiter_assert.sv
testbench/rd_checker.sv
testbench/tb_mem_read_subsys.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_mem_read_subsys
FILELIST := compile.f
OBJDIR   := obj_dir
RUNFLAGS := +verilator+error+limit+100
PASS_MSG := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* testbench/tb_mem_read_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_read_subsys
    import mem_types_pkg::*;
();

    localparam int DEPTH_WORDS  = 256;
    localparam int READ_LATENCY = 3;
    localparam int N_FETCH      = 60;
    localparam int N_LOAD       = 80;
    localparam int N_MIX        = 20;
    localparam int N_CONT       = 30;
    localparam int N_BAD        = 4;
    localparam int N_FILL       = 2 * DEPTH_WORDS + 2 * N_BAD;
    localparam int N_READS      = N_FETCH + N_LOAD + 2 * N_MIX + 2 * N_CONT + 2 * N_BAD;
    localparam int WATCHDOG_CYCLES = N_FILL + N_READS * (READ_LATENCY + 6) + 100;

    logic      clk;
    logic      rst;
    logic      if_valid;
    addr_t     if_addr;
    logic      if_data_valid;
    data_t     if_data;
    logic      ld_valid;
    addr_t     ld_addr;
    ld_size_t  ld_size;
    logic      ld_data_valid;
    data_t     ld_data;
    logic      ld_err;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    logic      pready;
    logic      pslverr;
    int        seed = 51046;
    int        unanswered = 0;   // requests that never saw a data pulse
    int        chk_errors;
    int        chk_checks;

    mem_read_subsys #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_mem_read_subsys (
        .clk (clk), .rst (rst),
        .if_valid_i (if_valid), .if_addr_i (if_addr),
        .if_data_valid_o (if_data_valid), .if_data_o (if_data),
        .ld_valid_i (ld_valid), .ld_addr_i (ld_addr), .ld_size_i (ld_size),
        .ld_data_valid_o (ld_data_valid), .ld_data_o (ld_data), .ld_err_o (ld_err),
        .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
        .pwdata_i (pwdata), .pready_o (pready), .pslverr_o (pslverr)
    );

    rd_checker #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_rd_checker (
        .clk (clk), .rst (rst),
        .if_valid_i (if_valid), .if_addr_i (if_addr),
        .if_data_valid_i (if_data_valid), .if_data_i (if_data),
        .ld_valid_i (ld_valid), .ld_addr_i (ld_addr), .ld_size_i (ld_size),
        .ld_data_valid_i (ld_data_valid), .ld_data_i (ld_data), .ld_err_i (ld_err),
        .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
        .pwdata_i (pwdata), .pready_i (pready), .pslverr_i (pslverr),
        .errors_o (chk_errors), .checks_o (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // request tasks
    // ------------------------------
    task automatic fetch_read(input addr_t addr, input int gap);
        int waited;
        waited = 0;
        repeat (gap + 1) @(posedge clk);
        #2;
        if_valid = 1'b1;
        if_addr  = addr;
        do begin
            @(negedge clk);
            waited++;
        end while (!if_data_valid && waited < 40);
        if (!if_data_valid) begin
            unanswered++;
            $display("fetch from %h got no response", addr);
        end
        @(posedge clk);
        #2;
        if_valid = 1'b0;
    endtask

    task automatic load_read(input addr_t addr, input ld_size_t size, input int gap);
        int waited;
        waited = 0;
        repeat (gap + 1) @(posedge clk);
        #2;
        ld_valid = 1'b1;
        ld_addr  = addr;
        ld_size  = size;
        do begin
            @(negedge clk);
            waited++;
        end while (!ld_data_valid && waited < 40);
        if (!ld_data_valid) begin
            unanswered++;
            $display("load from %h got no response", addr);
        end
        @(posedge clk);
        #2;
        ld_valid = 1'b0;
    endtask

    task automatic aligned_load(input int gap);
        ld_size_t size;
        addr_t    addr;
        size = ld_size_t'($random(seed));
        addr = {$random(seed), $random(seed)};
        addr = addr & ~((64'd1 << size[1:0]) - 64'd1);
        load_read(addr, size, gap);
    endtask

    task automatic misaligned_load();
        ld_size_t size;
        addr_t    addr;
        size = ld_size_t'($random(seed));
        if (size[1:0] == 2'd0)
            size[1:0] = 2'd3;   // byte loads cannot be misaligned
        addr = {$random(seed), $random(seed)};
        if ((addr & ((64'd1 << size[1:0]) - 64'd1)) == 64'd0)
            addr = addr | 64'd1;
        load_read(addr, size, 0);
    endtask

    // called at 2 ns after an edge, returns the same way
    task automatic apb_access(input apb_addr_t addr, input logic write, input apb_data_t data);
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        int total;
        if_valid = 1'b0;
        if_addr  = '0;
        ld_valid = 1'b0;
        ld_addr  = '0;
        ld_size  = '0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        rst      = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge clk);   // quiet window, no responses expected
        #2;

        for (int w = 0; w < DEPTH_WORDS; w++) begin
            apb_access(apb_addr_t'(w * 8), 1'b1, $random(seed));
            apb_access(apb_addr_t'(w * 8 + 4), 1'b1, $random(seed));
        end

        for (int i = 0; i < N_FETCH; i++)
            fetch_read({$random(seed), $random(seed)}, $random(seed) & 1);
        for (int i = 0; i < N_LOAD; i++)
            aligned_load($random(seed) & 1);

        // misaligned loads beside fetches
        fork
            for (int i = 0; i < N_MIX; i++)
                fetch_read({$random(seed), $random(seed)}, $random(seed) & 1);
            for (int i = 0; i < N_MIX; i++)
                misaligned_load();
        join

        // both sides held back to back
        fork
            for (int i = 0; i < N_CONT; i++)
                fetch_read({$random(seed), $random(seed)}, 0);
            for (int i = 0; i < N_CONT; i++)
                aligned_load(0);
        join

        @(posedge clk);
        #2;
        for (int k = 0; k < N_BAD; k++) begin
            apb_access(apb_addr_t'(DEPTH_WORDS * 8 + k * 8), 1'b1, $random(seed));
            apb_access(apb_addr_t'(k * 8 + 4), 1'b0, 32'h0);
        end
        for (int k = 0; k < N_BAD; k++) begin
            fetch_read(addr_t'(k * 8), 0);
            load_read(addr_t'(k * 8), 3'b011, 0);
        end

        repeat (4) @(posedge clk);
        total = chk_errors + unanswered +
                u_mem_read_subsys.u_rd_arbiter.u_rd_arbiter_assert.violations;
        $display("checks %0d, errors %0d, unanswered %0d, assertion failures %0d",
                 chk_checks, chk_errors, unanswered,
                 u_mem_read_subsys.u_rd_arbiter.u_rd_arbiter_assert.violations);
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_checker
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS  = 256,
    parameter int READ_LATENCY = 3
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             if_valid_i,
    input  wire addr_t      if_addr_i,
    input  wire             if_data_valid_i,
    input  wire data_t      if_data_i,
    input  wire             ld_valid_i,
    input  wire addr_t      ld_addr_i,
    input  wire ld_size_t   ld_size_i,
    input  wire             ld_data_valid_i,
    input  wire data_t      ld_data_i,
    input  wire             ld_err_i,
    input  wire apb_addr_t  paddr_i,
    input  wire             psel_i,
    input  wire             penable_i,
    input  wire             pwrite_i,
    input  wire apb_data_t  pwdata_i,
    input  wire             pready_i,
    input  wire             pslverr_i,
    output int              errors_o,
    output int              checks_o
);

    data_t model [DEPTH_WORDS];   // copy of what the apb port wrote
    int    errors = 0;
    int    checks = 0;
    int    since_load = 8;        // cycles since an aligned load was pending
    int    fetch_cycles = 0;
    logic  fetch_busy = 1'b0;
    logic  fetch_quiet = 1'b0;
    int    expect_side = 0;       // 0 none, 1 fetch, 2 load
    logic  load_now;
    logic  bad_apb;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic logic misaligned(input addr_t a, input ld_size_t s);
        return (a & ((64'd1 << s[1:0]) - 64'd1)) != 64'd0;
    endfunction

    function automatic data_t word_at(input addr_t a);
        return model[int'((a >> 3) % DEPTH_WORDS)];
    endfunction

    // pick the addressed bytes, then sign or zero extend
    function automatic data_t load_value(input addr_t a, input ld_size_t s);
        data_t word;
        data_t mask;
        int    nbits;
        nbits = 8 << s[1:0];
        word  = word_at(a) >> (8 * a[2:0]);
        if (nbits == 64)
            return word;
        mask = (64'd1 << nbits) - 64'd1;
        word = word & mask;
        if (!s[2] && word[nbits-1])
            word = word | ~mask;
        return word;
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            load_now = ld_valid_i && !misaligned(ld_addr_i, ld_size_i);

            // ------------------------------
            // apb fill port
            // ------------------------------
            if (psel_i && penable_i) begin
                bad_apb = !pwrite_i || (paddr_i >= DEPTH_WORDS * 8);
                check_value("pready_o", data_t'(pready_i), 64'd1);
                check_value("pslverr_o", data_t'(pslverr_i), data_t'(bad_apb));
                if (!bad_apb && paddr_i[2])
                    model[paddr_i >> 3][63:32] = pwdata_i;
                else if (!bad_apb)
                    model[paddr_i >> 3][31:0] = pwdata_i;
            end

            // fetch latency, counted only with no aligned load nearby
            if (if_valid_i && !fetch_busy) begin
                fetch_busy   = 1'b1;
                fetch_cycles = 0;
                fetch_quiet  = (since_load >= 2) && !load_now;
            end else if (fetch_busy) begin
                fetch_cycles++;
                if (load_now)
                    fetch_quiet = 1'b0;
            end

            // ------------------------------
            // responses
            // ------------------------------
            if (if_data_valid_i) begin
                if (!if_valid_i)
                    note_failure("fetch data valid without a fetch request");
                check_value("if_data_o", if_data_i, word_at(if_addr_i));
                if (fetch_quiet && fetch_cycles != READ_LATENCY)
                    note_failure($sformatf("fetch took %0d cycles instead of %0d",
                                           fetch_cycles, READ_LATENCY));
                fetch_busy = 1'b0;
            end

            if (ld_data_valid_i) begin
                if (!ld_valid_i)
                    note_failure("load data valid without a load request");
                check_value("ld_err_o", data_t'(ld_err_i),
                            data_t'(misaligned(ld_addr_i, ld_size_i)));
                check_value("ld_data_o", ld_data_i, misaligned(ld_addr_i, ld_size_i) ?
                            64'd0 : load_value(ld_addr_i, ld_size_i));
            end

            // a waiting requester is served next
            if (if_data_valid_i || (ld_data_valid_i && !ld_err_i)) begin
                if ((expect_side == 1 && !if_data_valid_i) || (expect_side == 2 && if_data_valid_i))
                    note_failure("fetch and load responses did not alternate");
                if (if_data_valid_i)
                    expect_side = load_now ? 2 : 0;
                else
                    expect_side = if_valid_i ? 1 : 0;
            end

            if (load_now)
                since_load = 0;
            else if (since_load < 8)
                since_load++;
        end
    end

endmodule

`default_nettype wire

/* testbench/rd_arbiter_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_arbiter_assert
    import arb_pkg::*;
(
    input wire             clk,
    input wire             rst,
    input wire arb_state_t state_i,
    input wire             if_data_valid_i,
    input wire             ls_data_valid_i
);

    int violations = 0;   // read by the testbench top

    state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state_i))
        else begin
            violations++;
            $error("arbiter state %b is not one-hot", state_i);
        end

    // a data pulse reaches only the side that holds the grant
    single_response: assert property (@(posedge clk) disable iff (rst)
        (!if_data_valid_i || state_i == ARB_FETCH) &&
        (!ls_data_valid_i || state_i == ARB_LOAD))
        else begin
            violations++;
            $error("data pulse routed to a side without the grant");
        end

    // grant only moves in the cycle after the one that saw the data pulse
    grant_held: assert property (@(posedge clk) disable iff (rst)
        (state_i != ARB_IDLE && !$past(if_data_valid_i || ls_data_valid_i))
        |=> $stable(state_i))
        else begin
            violations++;
            $error("grant changed without a finished transfer");
        end

endmodule

bind rd_arbiter rd_arbiter_assert u_rd_arbiter_assert (
    .clk             (clk),
    .rst             (rst),
    .state_i         (state_q),
    .if_data_valid_i (if_data_valid_o),
    .ls_data_valid_i (ls_data_valid_o)
);

`default_nettype wire

/* hw/mem_read_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_read_subsys
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS  = 256,
    parameter int READ_LATENCY = 3
) (
    input  wire             clk,
    input  wire             rst,

    // instruction fetch port
    input  wire             if_valid_i,
    input  wire addr_t      if_addr_i,
    output logic            if_data_valid_o,
    output data_t           if_data_o,

    // data load port
    input  wire             ld_valid_i,
    input  wire addr_t      ld_addr_i,
    input  wire ld_size_t   ld_size_i,
    output logic            ld_data_valid_o,
    output data_t           ld_data_o,
    output logic            ld_err_o,

    // apb fill port
    input  wire apb_addr_t  paddr_i,
    input  wire             psel_i,
    input  wire             penable_i,
    input  wire             pwrite_i,
    input  wire apb_data_t  pwdata_i,
    output logic            pready_o,
    output logic            pslverr_o
);

    // aligner to arbiter
    logic  ls_valid;
    addr_t ls_addr;
    logic  ls_data_valid;
    data_t ls_data;

    // arbiter to memory
    logic  rd_addr_valid;
    addr_t rd_addr;
    logic  rd_data_valid;
    data_t rd_data;

    load_align u_load_align (
        .ld_valid_i      (ld_valid_i),
        .ld_addr_i       (ld_addr_i),
        .ld_size_i       (ld_size_i),
        .ld_data_valid_o (ld_data_valid_o),
        .ld_data_o       (ld_data_o),
        .ld_err_o        (ld_err_o),
        .ls_valid_o      (ls_valid),
        .ls_addr_o       (ls_addr),
        .ls_data_valid_i (ls_data_valid),
        .ls_data_i       (ls_data)
    );

    rd_arbiter u_rd_arbiter (
        .clk             (clk),
        .rst             (rst),
        .if_valid_i      (if_valid_i),
        .if_addr_i       (if_addr_i),
        .if_data_valid_o (if_data_valid_o),
        .if_data_o       (if_data_o),
        .ls_valid_i      (ls_valid),
        .ls_addr_i       (ls_addr),
        .ls_data_valid_o (ls_data_valid),
        .ls_data_o       (ls_data),
        .rd_addr_valid_o (rd_addr_valid),
        .rd_addr_o       (rd_addr),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data)
    );

    read_memory #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_read_memory (
        .clk             (clk),
        .rst             (rst),
        .rd_addr_valid_i (rd_addr_valid),
        .rd_addr_i       (rd_addr),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data),
        .paddr_i         (paddr_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .pwdata_i        (pwdata_i),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o)
    );

endmodule

`default_nettype wire

/* hw/read_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module read_memory
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS  = 256,
    parameter int READ_LATENCY = 3
) (
    input  wire             clk,
    input  wire             rst,

    // read channel
    input  wire             rd_addr_valid_i,
    input  wire addr_t      rd_addr_i,
    output logic            rd_data_valid_o,
    output data_t           rd_data_o,

    // apb fill port, writes only
    input  wire apb_addr_t  paddr_i,
    input  wire             psel_i,
    input  wire             penable_i,
    input  wire             pwrite_i,
    input  wire apb_data_t  pwdata_i,
    output logic            pready_o,
    output logic            pslverr_o
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);   // depth is a power of two
    localparam int CNT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_RECOVER
    } mem_state_t;

    data_t            mem_q [DEPTH_WORDS];
    mem_state_t       state_q;
    logic [CNT_W-1:0] wait_cnt_q;
    data_t            rd_data_q;
    logic             accept;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] fill_idx;
    logic             apb_access;
    logic             fill_in_range;
    logic             fill_wr;

    // ------------------------------
    // read side
    // ------------------------------
    assign accept = rd_addr_valid_i && (state_q == MEM_IDLE);
    assign rd_idx = rd_addr_i[3 +: IDX_W];   // wraps modulo depth

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= MEM_IDLE;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (accept) begin
                        state_q    <= MEM_WAIT;
                        wait_cnt_q <= CNT_W'(READ_LATENCY - 1);
                    end
                end
                MEM_WAIT: begin
                    if (wait_cnt_q == '0)
                        state_q <= MEM_RECOVER;   // pulse goes out this cycle
                    else
                        wait_cnt_q <= wait_cnt_q - 1'b1;
                end
                default: state_q <= MEM_IDLE;   // one dead cycle after the pulse
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            rd_data_q <= mem_q[rd_idx];
    end

    assign rd_data_valid_o = (state_q == MEM_WAIT) && (wait_cnt_q == '0);
    assign rd_data_o       = rd_data_q;

    // ------------------------------
    // apb fill
    // ------------------------------
    assign apb_access    = psel_i && penable_i;
    assign fill_in_range = (paddr_i[31:3] < DEPTH_WORDS);
    assign fill_idx      = paddr_i[3 +: IDX_W];
    assign fill_wr       = apb_access && pwrite_i && fill_in_range;

    assign pready_o  = apb_access;   // no wait states
    assign pslverr_o = apb_access && (!pwrite_i || !fill_in_range);

    always_ff @(posedge clk) begin
        if (fill_wr) begin
            if (paddr_i[2])
                mem_q[fill_idx][63:32] <= pwdata_i;
            else
                mem_q[fill_idx][31:0] <= pwdata_i;
        end
    end

endmodule

`default_nettype wire

/* hw/rd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_arbiter
    import mem_types_pkg::*;
    import arb_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // fetch side
    input  wire         if_valid_i,
    input  wire addr_t  if_addr_i,
    output logic        if_data_valid_o,
    output data_t       if_data_o,

    // load side
    input  wire         ls_valid_i,
    input  wire addr_t  ls_addr_i,
    output logic        ls_data_valid_o,
    output data_t       ls_data_o,

    // shared channel
    output logic        rd_addr_valid_o,
    output addr_t       rd_addr_o,
    input  wire         rd_data_valid_i,
    input  wire data_t  rd_data_i
);

    arb_state_t state_q;
    arb_state_t state_d;
    logic       xfer_done_q;   // data pulse met a valid request last cycle
    logic       load_sel;
    logic       fetch_hold;

    // ------------------------------
    // grant state
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ARB_IDLE;
            xfer_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            xfer_done_q <= rd_data_valid_i && rd_addr_valid_o;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (ls_valid_i)
                    state_d = ARB_LOAD;   // load wins from idle
                else if (if_valid_i)
                    state_d = ARB_FETCH;
            end
            ARB_FETCH: begin
                if (xfer_done_q) begin
                    if (ls_valid_i)
                        state_d = ARB_LOAD;
                    else if (if_valid_i)
                        state_d = ARB_FETCH;
                    else
                        state_d = ARB_IDLE;
                end
            end
            ARB_LOAD: begin
                if (xfer_done_q) begin
                    if (if_valid_i)   // fetch gets its turn after a load
                        state_d = ARB_FETCH;
                    else if (ls_valid_i)
                        state_d = ARB_LOAD;
                    else
                        state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    // ------------------------------
    // channel mux
    // ------------------------------
    assign load_sel = (state_q == ARB_LOAD);

    // in idle a pending load blocks the fetch so memory never serves the loser
    assign fetch_hold = (state_q == ARB_IDLE) && ls_valid_i;

    assign rd_addr_valid_o = load_sel ? ls_valid_i : (if_valid_i && !fetch_hold);
    assign rd_addr_o       = load_sel ? ls_addr_i  : if_addr_i;

    assign if_data_o = rd_data_i;
    assign ls_data_o = rd_data_i;

    assign if_data_valid_o = !load_sel && rd_data_valid_i;
    assign ls_data_valid_o = load_sel && rd_data_valid_i;

endmodule

`default_nettype wire

/* hw/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align
    import mem_types_pkg::*;
(
    // load request from the core
    input  wire            ld_valid_i,
    input  wire addr_t     ld_addr_i,
    input  wire ld_size_t  ld_size_i,
    output logic           ld_data_valid_o,
    output data_t          ld_data_o,
    output logic           ld_err_o,

    // word read toward the arbiter
    output logic           ls_valid_o,
    output addr_t          ls_addr_o,
    input  wire            ls_data_valid_i,
    input  wire data_t     ls_data_i
);

    logic  misaligned;
    logic  sext;        // sign extend when size bit 2 is clear
    data_t shifted;
    data_t ext_data;

    always_comb begin
        case (ld_size_i[1:0])
            2'd0:    misaligned = 1'b0;
            2'd1:    misaligned = ld_addr_i[0];
            2'd2:    misaligned = |ld_addr_i[1:0];
            default: misaligned = |ld_addr_i[2:0];
        endcase
    end

    // ------------------------------
    // request side
    // ------------------------------
    assign ls_valid_o = ld_valid_i && !misaligned;
    assign ls_addr_o  = {ld_addr_i[63:3], 3'b000};
    assign ld_err_o   = ld_valid_i && misaligned;

    // ------------------------------
    // response side
    // ------------------------------
    assign sext    = !ld_size_i[2];
    assign shifted = ls_data_i >> {ld_addr_i[2:0], 3'b000};   // addressed byte to lane 0

    always_comb begin
        case (ld_size_i[1:0])
            2'd0:    ext_data = {{56{sext && shifted[7]}}, shifted[7:0]};
            2'd1:    ext_data = {{48{sext && shifted[15]}}, shifted[15:0]};
            2'd2:    ext_data = {{32{sext && shifted[31]}}, shifted[31:0]};
            default: ext_data = shifted;
        endcase
    end

    assign ld_data_valid_o = ls_data_valid_i || ld_err_o;
    assign ld_data_o       = ld_err_o ? '0 : ext_data;   // refused loads return zero

endmodule

`default_nettype wire

/* hw/arb_pkg.sv */
`default_nettype none

package arb_pkg;

    // one-hot grant state of the read channel arbiter
    typedef enum logic [2:0] {
        ARB_IDLE  = 3'b001,
        ARB_FETCH = 3'b010,   // channel owned by instruction fetch
        ARB_LOAD  = 3'b100    // channel owned by data load
    } arb_state_t;

endpackage

`default_nettype wire

/* hw/mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    // ------------------------------
    // core side
    // ------------------------------
    typedef logic [63:0] addr_t;   // byte address
    typedef logic [63:0] data_t;   // one memory word

    // [1:0] log2 of byte count, [2] set for zero extend
    typedef logic [2:0] ld_size_t;

    // ------------------------------
    // apb fill port
    // ------------------------------
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire
